// File: design/rab_macros.svh
/* Widths and table size of the lookup core. RAB_IN_ADDR_W must be at least 8,
   and RAB_OUT_ADDR_W must not be smaller than RAB_IN_ADDR_W */
`ifndef RAB_MACROS_SVH
`define RAB_MACROS_SVH

// Translation table size
`define RAB_N_SLICES     4

// Requester side and master side address widths
`define RAB_IN_ADDR_W    32
`define RAB_OUT_ADDR_W   40

// Transaction side-band fields
`define RAB_ID_W         8
`define RAB_USER_W       6

// Bytes moved per beat, used for the burst end address
`define RAB_BURST_BYTES  8

`endif

// File: design/rab_pkg.sv
/* Shared types of the lookup core. Widths come from rab_macros.svh */
`default_nettype none
`include "rab_macros.svh"

package rab_pkg;

  // Requester a request came from
  typedef enum logic {
    PORT1 = 1'b0,
    PORT2 = 1'b1
  } rab_port_e;

  typedef struct packed {
    rab_port_e                  port;
    logic                       is_write;
    logic [`RAB_ID_W-1:0]       id;
    logic [7:0]                 len;
    logic [`RAB_USER_W-1:0]     user;
    logic [`RAB_IN_ADDR_W-1:0]  addr_min;
    // Last byte of the burst, inclusive
    logic [`RAB_IN_ADDR_W-1:0]  addr_max;
  } rab_req_t;

  typedef struct packed {
    logic                       en;
    logic                       rd_en;
    logic                       wr_en;
    logic                       prefetch;
    logic                       coherent;
    logic [`RAB_IN_ADDR_W-1:0]  addr_min;
    logic [`RAB_IN_ADDR_W-1:0]  addr_max;
    logic [`RAB_OUT_ADDR_W-1:0] offset;
  } rab_slice_t;

  typedef struct packed {
    rab_req_t                   req;
    logic                       no_hit;
    logic                       multi_hit;
    logic                       no_prot;
    logic                       prefetch;
    logic                       coherent;
    logic [`RAB_OUT_ADDR_W-1:0] out_addr;
  } rab_lookup_t;

endpackage

`default_nettype wire

// File: design/rab_stage_if.sv
/* Valid/ready link between two pipeline stages. The producer holds valid and
   payload until an edge sees both valid and ready high */
`default_nettype none

interface rab_stage_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t payload;

  modport producer (
    output valid,
    output payload,
    input  ready
  );

  // Consumer may derive ready from valid
  modport consumer (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// File: design/rab_port_arbiter.sv
/* Round-robin choice between two requester ports into a one-entry register.
   Burst end addresses that wrap past the top of the address space are not handled */
`default_nettype none
`include "rab_macros.svh"

module rab_port_arbiter (
  input  wire logic                      Clk_CI,
  input  wire logic                      Rst_RBI,
  input  wire logic                      port1_valid_i,
  output logic                           port1_ready_o,
  input  wire logic                      port1_write_i,
  input  wire logic [`RAB_IN_ADDR_W-1:0] port1_addr_i,
  input  wire logic [`RAB_ID_W-1:0]      port1_id_i,
  input  wire logic [7:0]                port1_len_i,
  input  wire logic [`RAB_USER_W-1:0]    port1_user_i,
  input  wire logic                      port2_valid_i,
  output logic                           port2_ready_o,
  input  wire logic                      port2_write_i,
  input  wire logic [`RAB_IN_ADDR_W-1:0] port2_addr_i,
  input  wire logic [`RAB_ID_W-1:0]      port2_id_i,
  input  wire logic [7:0]                port2_len_i,
  input  wire logic [`RAB_USER_W-1:0]    port2_user_i,
  rab_stage_if.producer                  req_o
);
  import rab_pkg::*;

  // High when port 2 has priority on the next conflict
  logic                      rr_q;
  logic                      out_valid_q;
  rab_req_t                  out_req_q;
  rab_req_t                  req_d;
  logic                      load_en;
  logic                      take1;
  logic                      take2;
  logic [`RAB_IN_ADDR_W-1:0] len_ext;
  logic [`RAB_IN_ADDR_W-1:0] burst_bytes;

  assign load_en = ~out_valid_q | req_o.ready;

  // A port is only held off when the other one is valid and has priority
  assign port1_ready_o = load_en & ~(port2_valid_i & rr_q);
  assign port2_ready_o = load_en & ~(port1_valid_i & ~rr_q);

  assign take1 = port1_valid_i & port1_ready_o;
  assign take2 = port2_valid_i & port2_ready_o;

  always_comb begin
    if (take2) begin
      req_d.port     = PORT2;
      req_d.is_write = port2_write_i;
      req_d.id       = port2_id_i;
      req_d.len      = port2_len_i;
      req_d.user     = port2_user_i;
      req_d.addr_min = port2_addr_i;
    end else begin
      req_d.port     = PORT1;
      req_d.is_write = port1_write_i;
      req_d.id       = port1_id_i;
      req_d.len      = port1_len_i;
      req_d.user     = port1_user_i;
      req_d.addr_min = port1_addr_i;
    end
    // len counts beats minus one
    len_ext        = {{(`RAB_IN_ADDR_W-8){1'b0}}, req_d.len};
    burst_bytes    = (len_ext + 1'b1) * (`RAB_IN_ADDR_W)'(`RAB_BURST_BYTES);
    req_d.addr_max = req_d.addr_min + burst_bytes - 1'b1;
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      rr_q        <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (take1) begin
        rr_q <= 1'b1;
      end else if (take2) begin
        rr_q <= 1'b0;
      end
      if (load_en) begin
        out_valid_q <= take1 | take2;
      end
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (take1 | take2) begin
      out_req_q <= req_d;
    end
  end

  assign req_o.valid   = out_valid_q;
  assign req_o.payload = out_req_q;

endmodule

`default_nettype wire

// File: design/rab_slice_table.sv
/* Slice storage with parallel range compare and translation, one-entry output stage.
   A burst hits only when it lies fully inside a slice. The lowest-index hit slice wins */
`default_nettype none
`include "rab_macros.svh"

module rab_slice_table (
  input  wire logic                             Clk_CI,
  input  wire logic                             Rst_RBI,
  input  wire logic                             cfg_we_i,
  input  wire logic [$clog2(`RAB_N_SLICES)-1:0] cfg_idx_i,
  input  wire rab_pkg::rab_slice_t              cfg_slice_i,
  rab_stage_if.consumer                         req_i,
  rab_stage_if.producer                         lkp_o
);
  import rab_pkg::*;

  rab_slice_t               slices_q [`RAB_N_SLICES];
  logic [`RAB_N_SLICES-1:0] hit;
  rab_slice_t               sel_slice;
  rab_req_t                 req;
  rab_lookup_t              lkp_d;
  rab_lookup_t              lkp_q;
  logic                     lkp_valid_q;
  logic                     load_en;

  assign req = req_i.payload;

  // Configuration write port
  always_ff @(posedge Clk_CI, negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      for (int i = 0; i < `RAB_N_SLICES; i++) begin
        slices_q[i] <= '0;
      end
    end else if (cfg_we_i) begin
      slices_q[cfg_idx_i] <= cfg_slice_i;
    end
  end

  always_comb begin
    for (int i = 0; i < `RAB_N_SLICES; i++) begin
      hit[i] = slices_q[i].en
             & (req.addr_min >= slices_q[i].addr_min)
             & (req.addr_max <= slices_q[i].addr_max);
    end
  end

  // Walk downwards so the lowest index is picked last
  always_comb begin
    sel_slice = '0;
    for (int i = `RAB_N_SLICES-1; i >= 0; i--) begin
      if (hit[i]) begin
        sel_slice = slices_q[i];
      end
    end
  end

  always_comb begin
    lkp_d.req       = req;
    lkp_d.no_hit    = ~|hit;
    // Two or more bits set leave something after clearing the lowest one
    lkp_d.multi_hit = |(hit & (hit - 1'b1));
    // A miss is reported as a miss only, never as a protection fault
    lkp_d.no_prot   = lkp_d.no_hit | (req.is_write ? sel_slice.wr_en : sel_slice.rd_en);
    lkp_d.prefetch  = sel_slice.prefetch;
    lkp_d.coherent  = sel_slice.coherent;
    lkp_d.out_addr  = {{(`RAB_OUT_ADDR_W-`RAB_IN_ADDR_W){1'b0}},
                       req.addr_min - sel_slice.addr_min} + sel_slice.offset;
  end

  assign load_en     = ~lkp_valid_q | lkp_o.ready;
  assign req_i.ready = load_en;

  always_ff @(posedge Clk_CI, negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      lkp_valid_q <= 1'b0;
    end else if (load_en) begin
      lkp_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (load_en & req_i.valid) begin
      lkp_q <= lkp_d;
    end
  end

  assign lkp_o.valid   = lkp_valid_q;
  assign lkp_o.payload = lkp_q;

endmodule

`default_nettype wire

// File: design/rab_decision_fsm.sv
/* Registers one lookup decision and holds it until sent_i. Only one decision is
   outstanding. Invalidation stalls the stage and does not touch the table */
`default_nettype none
`include "rab_macros.svh"

module rab_decision_fsm (
  input  wire logic                   Clk_CI,
  input  wire logic                   Rst_RBI,
  rab_stage_if.consumer               lkp_i,
  input  wire logic                   sent_i,
  input  wire logic                   invalidate_i,
  output logic                        port1_accept_o,
  output logic                        port1_drop_o,
  output logic                        port1_miss_o,
  output logic                        port2_accept_o,
  output logic                        port2_drop_o,
  output logic                        port2_miss_o,
  output logic                        miss_o,
  output logic                        multi_o,
  output logic                        prot_o,
  output logic                        prefetch_o,
  output logic                        invalidate_o,
  output logic                        cache_coherent_o,
  output logic [`RAB_OUT_ADDR_W-1:0]  out_addr_o,
  output logic [`RAB_IN_ADDR_W-1:0]   in_addr_min_o,
  output logic [`RAB_IN_ADDR_W-1:0]   in_addr_max_o,
  output logic [`RAB_ID_W-1:0]        in_id_o,
  output logic [7:0]                  in_len_o,
  output logic [`RAB_USER_W-1:0]      in_user_o
);
  import rab_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT_SENT, WAIT_INVALIDATE} state_e;

  state_e      state_q;
  state_e      state_d;
  rab_lookup_t lkp;
  logic        drop;
  logic        is_port2;
  logic        load_dec;
  logic        clear_dec;
  logic        inv_en;

  assign lkp         = lkp_i.payload;
  assign lkp_i.ready = (state_q == IDLE) & ~invalidate_i;

  assign drop     = lkp.no_hit | lkp.multi_hit | ~lkp.no_prot | lkp.prefetch;
  assign is_port2 = (lkp.req.port == PORT2);

  always_comb begin
    state_d   = state_q;
    load_dec  = 1'b0;
    clear_dec = 1'b0;
    inv_en    = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (invalidate_i) begin
          inv_en  = 1'b1;
          state_d = WAIT_INVALIDATE;
        end else if (lkp_i.valid) begin
          load_dec = 1'b1;
          state_d  = WAIT_SENT;
        end
      end
      WAIT_SENT: begin
        if (sent_i) begin
          clear_dec = 1'b1;
          state_d   = IDLE;
        end
      end
      WAIT_INVALIDATE: begin
        if (!invalidate_i) begin
          inv_en  = 1'b1;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      port1_accept_o   <= 1'b0;
      port1_drop_o     <= 1'b0;
      port1_miss_o     <= 1'b0;
      port2_accept_o   <= 1'b0;
      port2_drop_o     <= 1'b0;
      port2_miss_o     <= 1'b0;
      miss_o           <= 1'b0;
      multi_o          <= 1'b0;
      prot_o           <= 1'b0;
      prefetch_o       <= 1'b0;
      invalidate_o     <= 1'b0;
      cache_coherent_o <= 1'b0;
      out_addr_o       <= '0;
      in_addr_min_o    <= '0;
      in_addr_max_o    <= '0;
      in_id_o          <= '0;
      in_len_o         <= '0;
      in_user_o        <= '0;
    end else begin
      if (load_dec) begin
        port1_accept_o   <= ~drop & ~is_port2;
        port1_drop_o     <= drop & ~is_port2;
        port1_miss_o     <= lkp.no_hit & ~is_port2;
        port2_accept_o   <= ~drop & is_port2;
        port2_drop_o     <= drop & is_port2;
        port2_miss_o     <= lkp.no_hit & is_port2;
        miss_o           <= lkp.no_hit;
        multi_o          <= lkp.multi_hit;
        prot_o           <= ~lkp.no_prot;
        prefetch_o       <= ~lkp.no_hit & lkp.prefetch;
        cache_coherent_o <= lkp.coherent;
        out_addr_o       <= lkp.out_addr;
        in_addr_min_o    <= lkp.req.addr_min;
        in_addr_max_o    <= lkp.req.addr_max;
        in_id_o          <= lkp.req.id;
        in_len_o         <= lkp.req.len;
        in_user_o        <= lkp.req.user;
      end else if (clear_dec) begin
        // Flags drop back, the address and echo fields keep the last request
        port1_accept_o   <= 1'b0;
        port1_drop_o     <= 1'b0;
        port1_miss_o     <= 1'b0;
        port2_accept_o   <= 1'b0;
        port2_drop_o     <= 1'b0;
        port2_miss_o     <= 1'b0;
        miss_o           <= 1'b0;
        multi_o          <= 1'b0;
        prot_o           <= 1'b0;
        prefetch_o       <= 1'b0;
        cache_coherent_o <= 1'b0;
      end
      if (inv_en) begin
        invalidate_o <= invalidate_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/rab_top.sv
/* Lookup core top level: arbiter, slice table and decision stage in a row.
   Slices are written directly through the cfg port, which has no back-pressure */
`default_nettype none
`include "rab_macros.svh"

module rab_top (
  input  wire logic                             Clk_CI,
  input  wire logic                             Rst_RBI,
  input  wire logic                             port1_valid_i,
  output logic                                  port1_ready_o,
  input  wire logic                             port1_write_i,
  input  wire logic [`RAB_IN_ADDR_W-1:0]        port1_addr_i,
  input  wire logic [`RAB_ID_W-1:0]             port1_id_i,
  input  wire logic [7:0]                       port1_len_i,
  input  wire logic [`RAB_USER_W-1:0]           port1_user_i,
  input  wire logic                             port2_valid_i,
  output logic                                  port2_ready_o,
  input  wire logic                             port2_write_i,
  input  wire logic [`RAB_IN_ADDR_W-1:0]        port2_addr_i,
  input  wire logic [`RAB_ID_W-1:0]             port2_id_i,
  input  wire logic [7:0]                       port2_len_i,
  input  wire logic [`RAB_USER_W-1:0]           port2_user_i,
  input  wire logic                             cfg_we_i,
  input  wire logic [$clog2(`RAB_N_SLICES)-1:0] cfg_idx_i,
  input  wire rab_pkg::rab_slice_t              cfg_slice_i,
  input  wire logic                             sent_i,
  input  wire logic                             invalidate_i,
  output logic                                  port1_accept_o,
  output logic                                  port1_drop_o,
  output logic                                  port1_miss_o,
  output logic                                  port2_accept_o,
  output logic                                  port2_drop_o,
  output logic                                  port2_miss_o,
  output logic                                  miss_o,
  output logic                                  multi_o,
  output logic                                  prot_o,
  output logic                                  prefetch_o,
  output logic                                  invalidate_o,
  output logic                                  cache_coherent_o,
  output logic [`RAB_OUT_ADDR_W-1:0]            out_addr_o,
  output logic [`RAB_IN_ADDR_W-1:0]             in_addr_min_o,
  output logic [`RAB_IN_ADDR_W-1:0]             in_addr_max_o,
  output logic [`RAB_ID_W-1:0]                  in_id_o,
  output logic [7:0]                            in_len_o,
  output logic [`RAB_USER_W-1:0]                in_user_o
);
  import rab_pkg::*;

  rab_stage_if #(.payload_t(rab_req_t))    req_if ();
  rab_stage_if #(.payload_t(rab_lookup_t)) lkp_if ();

  rab_port_arbiter rab_port_arbiter_inst (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .port1_valid_i (port1_valid_i),
    .port1_ready_o (port1_ready_o),
    .port1_write_i (port1_write_i),
    .port1_addr_i  (port1_addr_i),
    .port1_id_i    (port1_id_i),
    .port1_len_i   (port1_len_i),
    .port1_user_i  (port1_user_i),
    .port2_valid_i (port2_valid_i),
    .port2_ready_o (port2_ready_o),
    .port2_write_i (port2_write_i),
    .port2_addr_i  (port2_addr_i),
    .port2_id_i    (port2_id_i),
    .port2_len_i   (port2_len_i),
    .port2_user_i  (port2_user_i),
    .req_o         (req_if.producer)
  );

  rab_slice_table rab_slice_table_inst (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .cfg_we_i    (cfg_we_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_slice_i (cfg_slice_i),
    .req_i       (req_if.consumer),
    .lkp_o       (lkp_if.producer)
  );

  rab_decision_fsm rab_decision_fsm_inst (
    .Clk_CI           (Clk_CI),
    .Rst_RBI          (Rst_RBI),
    .lkp_i            (lkp_if.consumer),
    .sent_i           (sent_i),
    .invalidate_i     (invalidate_i),
    .port1_accept_o   (port1_accept_o),
    .port1_drop_o     (port1_drop_o),
    .port1_miss_o     (port1_miss_o),
    .port2_accept_o   (port2_accept_o),
    .port2_drop_o     (port2_drop_o),
    .port2_miss_o     (port2_miss_o),
    .miss_o           (miss_o),
    .multi_o          (multi_o),
    .prot_o           (prot_o),
    .prefetch_o       (prefetch_o),
    .invalidate_o     (invalidate_o),
    .cache_coherent_o (cache_coherent_o),
    .out_addr_o       (out_addr_o),
    .in_addr_min_o    (in_addr_min_o),
    .in_addr_max_o    (in_addr_max_o),
    .in_id_o          (in_id_o),
    .in_len_o         (in_len_o),
    .in_user_o        (in_user_o)
  );

endmodule

`default_nettype wire

// File: sim/rab_tb.sv
/* Testbench for the lookup core. Slices are only reprogrammed while no request is
   in flight, so the shadow table matches the DUT table at every grant */
`default_nettype none
`include "rab_macros.svh"

module rab_tb;
  import rab_pkg::*;

  localparam int N_REQS = 23;

  typedef struct {
    rab_port_e                  port;
    logic                       drop;
    logic                       miss;
    logic                       multi;
    logic                       prot;
    logic                       pf;
    logic                       coh;
    logic [`RAB_OUT_ADDR_W-1:0] out_addr;
    logic [`RAB_IN_ADDR_W-1:0]  amin;
    logic [`RAB_IN_ADDR_W-1:0]  amax;
    logic [`RAB_ID_W-1:0]       id;
    logic [7:0]                 len;
    logic [`RAB_USER_W-1:0]     user;
  } exp_t;

  logic Clk_CI, Rst_RBI;
  logic port1_valid_i, port1_ready_o, port1_write_i;
  logic port2_valid_i, port2_ready_o, port2_write_i;
  logic [`RAB_IN_ADDR_W-1:0] port1_addr_i, port2_addr_i;
  logic [`RAB_ID_W-1:0] port1_id_i, port2_id_i;
  logic [7:0] port1_len_i, port2_len_i;
  logic [`RAB_USER_W-1:0] port1_user_i, port2_user_i;
  logic cfg_we_i, sent_i, invalidate_i;
  logic [$clog2(`RAB_N_SLICES)-1:0] cfg_idx_i;
  rab_slice_t cfg_slice_i;
  logic port1_accept_o, port1_drop_o, port1_miss_o;
  logic port2_accept_o, port2_drop_o, port2_miss_o;
  logic miss_o, multi_o, prot_o, prefetch_o, invalidate_o, cache_coherent_o;
  logic [`RAB_OUT_ADDR_W-1:0] out_addr_o;
  logic [`RAB_IN_ADDR_W-1:0] in_addr_min_o, in_addr_max_o;
  logic [`RAB_ID_W-1:0] in_id_o;
  logic [7:0] in_len_o;
  logic [`RAB_USER_W-1:0] in_user_o;

  rab_slice_t shadow [`RAB_N_SLICES];
  exp_t       exp_q [$];
  int         errors = 0;
  int         n_dec = 0;
  int         bp_seen = 0;
  rab_port_e  last_win = PORT2;
  logic       dec_prev = 1'b0;
  logic       dec_any;
  logic [11:0] dec_flags;
  event       decided;

  assign dec_any   = port1_accept_o | port1_drop_o | port2_accept_o | port2_drop_o;
  assign dec_flags = {port1_accept_o, port1_drop_o, port1_miss_o, port2_accept_o,
                      port2_drop_o, port2_miss_o, miss_o, multi_o, prot_o,
                      prefetch_o, cache_coherent_o, dec_any};

  rab_top rab_top_inst (.*);

  initial begin
    Clk_CI = 1'b0;
    forever #2 Clk_CI = ~Clk_CI;
  end

  // Port-level properties that hold for every decision
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !(port1_accept_o && port1_drop_o) && !(port2_accept_o && port2_drop_o)
    && !((port1_accept_o || port1_drop_o) && (port2_accept_o || port2_drop_o)))
  else begin
    $display("[ERROR] t=%0t accept and drop or both ports flagged together", $time);
    errors++;
  end

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    miss_o |-> (port1_drop_o || port2_drop_o))
  else begin
    $display("[ERROR] t=%0t miss flagged without a drop", $time);
    errors++;
  end

  // Nothing may move while the invalidation stall is shown
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    invalidate_o |=> $stable(dec_flags))
  else begin
    $display("[ERROR] t=%0t decision outputs changed during invalidation", $time);
    errors++;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else begin
      $display("[ERROR] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic rab_slice_t mk_slice(input logic rd, input logic wr, input logic pf,
      input logic coh, input logic [31:0] lo, input logic [31:0] hi, input logic [39:0] off);
    rab_slice_t s;
    s = '{en: 1'b1, rd_en: rd, wr_en: wr, prefetch: pf, coherent: coh,
          addr_min: lo, addr_max: hi, offset: off};
    return s;
  endfunction

  // Expected decision from the translation rules and the shadow table
  function automatic exp_t predict(input rab_port_e p, input logic wr,
      input logic [31:0] a, input logic [7:0] id, input logic [7:0] len, input logic [5:0] u);
    exp_t e;
    rab_slice_t sel;
    int nhit;
    nhit = 0;
    sel = '0;
    e.amin = a;
    e.amax = a + (32'(len) + 1) * `RAB_BURST_BYTES - 1;
    for (int i = `RAB_N_SLICES - 1; i >= 0; i--) begin
      if (shadow[i].en && a >= shadow[i].addr_min && e.amax <= shadow[i].addr_max) begin
        nhit++;
        sel = shadow[i];
      end
    end
    e.port = p;
    e.miss = (nhit == 0);
    e.multi = (nhit > 1);
    e.prot = !e.miss && !(wr ? sel.wr_en : sel.rd_en);
    e.pf = !e.miss && sel.prefetch;
    e.coh = sel.coherent;
    e.drop = e.miss || e.multi || e.prot || e.pf;
    e.out_addr = 40'(a - sel.addr_min) + sel.offset;
    e.id = id;
    e.len = len;
    e.user = u;
    return e;
  endfunction

  // Grants are recorded half a cycle before the edge that takes them
  always @(negedge Clk_CI) begin
    if (Rst_RBI) begin
      // Under conflict the grant goes to the port that did not win last
      if (port1_valid_i && port2_valid_i && (port1_ready_o || port2_ready_o)) begin
        check("port1_ready_o", port1_ready_o, last_win == PORT2);
        check("port2_ready_o", port2_ready_o, last_win == PORT1);
      end
      // Both readies low only while the pipeline is full
      if (port1_valid_i && !port1_ready_o && !port2_ready_o) bp_seen++;
      if (port1_valid_i && port1_ready_o) begin
        exp_q.push_back(predict(PORT1, port1_write_i, port1_addr_i, port1_id_i,
                                port1_len_i, port1_user_i));
        last_win = PORT1;
      end
      if (port2_valid_i && port2_ready_o) begin
        exp_q.push_back(predict(PORT2, port2_write_i, port2_addr_i, port2_id_i,
                                port2_len_i, port2_user_i));
        last_win = PORT2;
      end
    end
  end

  always @(negedge Clk_CI) begin
    exp_t e;
    if (dec_any && !dec_prev) begin
      if (exp_q.size() == 0) begin
        $display("[ERROR] t=%0t decision appeared without a granted request", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        n_dec++;
        check("port1_accept_o", port1_accept_o, e.port == PORT1 && !e.drop);
        check("port1_drop_o", port1_drop_o, e.port == PORT1 && e.drop);
        check("port1_miss_o", port1_miss_o, e.port == PORT1 && e.miss);
        check("port2_accept_o", port2_accept_o, e.port == PORT2 && !e.drop);
        check("port2_drop_o", port2_drop_o, e.port == PORT2 && e.drop);
        check("port2_miss_o", port2_miss_o, e.port == PORT2 && e.miss);
        check("miss_o", miss_o, e.miss);
        check("multi_o", multi_o, e.multi);
        check("prot_o", prot_o, e.prot);
        check("prefetch_o", prefetch_o, e.pf);
        check("cache_coherent_o", cache_coherent_o, e.coh);
        if (!e.drop) check("out_addr_o", out_addr_o, e.out_addr);
        check("in_addr_min_o", in_addr_min_o, e.amin);
        check("in_addr_max_o", in_addr_max_o, e.amax);
        check("in_id_o", in_id_o, e.id);
        check("in_len_o", in_len_o, e.len);
        check("in_user_o", in_user_o, e.user);
      end
      -> decided;
    end
    dec_prev = dec_any;
  end

  // Downstream side reports each decision sent after 1 to 4 cycles
  initial begin
    forever begin
      @(decided);
      repeat ($urandom_range(1, 4)) @(posedge Clk_CI);
      #1 sent_i = 1'b1;
      @(posedge Clk_CI);
      #1 sent_i = 1'b0;
      @(negedge Clk_CI);
      check("decision flags after sent", dec_flags, '0);
    end
  end

  initial begin
    repeat (200 * N_REQS) @(posedge Clk_CI);
    $display("Timeout: requests were not all decided in time");
    $display("Regression failed");
    $finish;
  end

  task automatic program_slice(input int idx, input rab_slice_t s);
    cfg_we_i = 1'b1;
    cfg_idx_i = idx[1:0];
    cfg_slice_i = s;
    @(posedge Clk_CI);
    #1 cfg_we_i = 1'b0;
    shadow[idx] = s;
  endtask

  // Called one time unit after an edge and returns at the same phase
  task automatic issue(input int p, input logic wr, input logic [31:0] a,
      input logic [7:0] len, input logic [7:0] id, input logic [5:0] u);
    if (p == 1) begin
      {port1_valid_i, port1_write_i, port1_addr_i} = {1'b1, wr, a};
      {port1_len_i, port1_id_i, port1_user_i} = {len, id, u};
    end else begin
      {port2_valid_i, port2_write_i, port2_addr_i} = {1'b1, wr, a};
      {port2_len_i, port2_id_i, port2_user_i} = {len, id, u};
    end
    do @(negedge Clk_CI); while (!(p == 1 ? port1_ready_o : port2_ready_o));
    @(posedge Clk_CI);
    #1;
    if (p == 1) port1_valid_i = 1'b0;
    else port2_valid_i = 1'b0;
  endtask

  task automatic drain();
    do @(negedge Clk_CI); while (exp_q.size() != 0 || dec_any);
    @(posedge Clk_CI);
    #1;
  endtask

  function automatic logic [31:0] pick_addr(input int region);
    logic [31:0] base;
    case (region)
      0: base = 32'h1000;
      1: base = 32'h2000;
      2: base = 32'h8000;
      default: base = 32'h6000;
    endcase
    return base + ($urandom_range(0, 63) << 4);
  endfunction

  task automatic stream(input int p);
    for (int k = 0; k < 6; k++) begin
      issue(p, 1'($urandom_range(0, 1)), pick_addr($urandom_range(0, 3)),
            8'($urandom_range(0, 3)), 8'($urandom), 6'($urandom));
    end
  endtask

  initial begin
    void'($urandom(71));
    {Rst_RBI, port1_valid_i, port1_write_i, port2_valid_i, port2_write_i} = '0;
    {port1_addr_i, port1_id_i, port1_len_i, port1_user_i} = '0;
    {port2_addr_i, port2_id_i, port2_len_i, port2_user_i} = '0;
    {cfg_we_i, cfg_idx_i, cfg_slice_i, sent_i, invalidate_i} = '0;
    for (int i = 0; i < `RAB_N_SLICES; i++) shadow[i] = '0;
    repeat (16) @(posedge Clk_CI);
    #1 Rst_RBI = 1'b1;
    @(negedge Clk_CI);
    check("decision outputs after reset", {dec_flags, invalidate_o, out_addr_o}, '0);
    check("port readies after reset", {port1_ready_o, port2_ready_o}, 2'b11);
    @(posedge Clk_CI);
    #1;

    // Accepted translation on both ports
    program_slice(0, mk_slice(1, 1, 0, 1, 32'h1000, 32'h1FFF, 40'h80_0000_0000));
    issue(1, 1'b0, 32'h1100, 8'd3, 8'h11, 6'd5);
    issue(2, 1'b1, 32'h1800, 8'd0, 8'h22, 6'd9);
    drain();

    // Miss by crossing, miss by no slice, then multi-hit
    issue(1, 1'b0, 32'h1FF0, 8'd3, 8'h31, 6'd1);
    issue(2, 1'b0, 32'h5000, 8'd1, 8'h32, 6'd2);
    drain();
    program_slice(1, mk_slice(1, 1, 0, 0, 32'h1800, 32'h2FFF, 40'h00_1234_0000));
    issue(1, 1'b0, 32'h1900, 8'd1, 8'h33, 6'd3);
    drain();

    // Protection fault and prefetch slice
    program_slice(2, mk_slice(1, 0, 0, 0, 32'h4000, 32'h4FFF, 40'h00_0001_0000));
    program_slice(3, mk_slice(1, 1, 1, 1, 32'h8000, 32'h8FFF, 40'h10_0000_0000));
    issue(2, 1'b1, 32'h4100, 8'd2, 8'h41, 6'd4);
    issue(1, 1'b0, 32'h8010, 8'd0, 8'h42, 6'd6);
    drain();

    // Stall under invalidation, pending requests decided in order afterwards
    invalidate_i = 1'b1;
    fork
      begin
        issue(1, 1'b0, 32'h1200, 8'd1, 8'h51, 6'd7);
        issue(2, 1'b0, 32'h5000, 8'd0, 8'h52, 6'd8);
        issue(1, 1'b1, 32'h4200, 8'd0, 8'h53, 6'd9);
        issue(2, 1'b0, 32'h2100, 8'd2, 8'h54, 6'd10);
      end
      begin
        @(posedge Clk_CI);
        repeat (12) begin
          @(negedge Clk_CI);
          check("invalidate_o", invalidate_o, 1'b1);
        end
        @(posedge Clk_CI);
        #1 invalidate_i = 1'b0;
      end
    join
    drain();
    check("invalidate_o after release", invalidate_o, 1'b0);

    // Both ports streaming, alternation and back-pressure
    fork
      stream(1);
      stream(2);
    join
    drain();

    if (bp_seen == 0) begin
      $display("Port 1 ready never fell while the pipeline was full");
      errors++;
    end
    if (n_dec != N_REQS) begin
      $display("Expected %0d decisions but saw %0d", N_REQS, n_dec);
      errors++;
    end
    $display("rab_tb: %0d decisions, %0d errors", n_dec, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/rab_pkg.sv
design/rab_stage_if.sv
design/rab_port_arbiter.sv
design/rab_slice_table.sv
design/rab_decision_fsm.sv
design/rab_top.sv
sim/rab_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module rab_tb -f list.f
	./obj_dir/Vrab_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
